// File: build.f
src/perv_cfg_pkg.sv
src/perv_event_pkg.sv
src/perv_cfg_regs.sv
src/debug_trace_stage.sv
src/perf_thread_events.sv
src/perf_event_select.sv
src/lq_perv_top.sv
verif/tb_lq_perv.sv

// File: Makefile
TOP = tb_lq_perv

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verif/tb_lq_perv.sv
// Pervasive block testbench
`timescale 1ns/1ps
`default_nettype none

module tb_lq_perv;

   localparam int THREADS = 2;
   localparam int LANES   = perv_event_pkg::EVENT_LANES;
   localparam int EVW     = THREADS * LANES;
   localparam int EX6W    = perv_event_pkg::EX6_EVENTS + THREADS;
   localparam int STQ4W   = perv_event_pkg::STQ4_EVENTS + THREADS;
   localparam int LESRW   = THREADS * 24;
   localparam int NUM_VEC = 24;
   localparam int TIMEOUT = 16;

   // one table entry with expected values from the reference model
   typedef struct packed {
      perv_cfg_pkg::count_mode_t   mode;
      perv_cfg_pkg::dbg_sel_t      sel1;
      perv_cfg_pkg::dbg_sel_t      sel2;
      logic [LESRW-1:0]            lesr;
      logic [THREADS-1:0]          pr;
      logic [THREADS-1:0]          gs;
      perv_event_pkg::trace_data_t dbg_in;
      perv_event_pkg::trace_data_t lq_dbg;
      perv_event_pkg::coretrace_t  ct_in;
      logic [EX6W-1:0]             ex6;
      logic [STQ4W-1:0]            stq4;
      logic [THREADS-1:0]          ex7;
      logic [EVW-1:0]              ev_in;
      perv_event_pkg::trace_data_t exp_trace;
      logic [EVW-1:0]              exp_events;
   } vec_t;

   logic                        nclk;
   logic                        arst_n;
   logic                        psel;
   logic                        penable;
   logic                        pwrite;
   perv_cfg_pkg::apb_addr_t     paddr;
   perv_cfg_pkg::apb_data_t     pwdata;
   perv_cfg_pkg::apb_data_t     prdata;
   logic                        pready;
   logic                        pslverr;
   perv_event_pkg::trace_data_t debug_bus_in;
   perv_event_pkg::coretrace_t  coretrace_ctrls_in;
   perv_event_pkg::trace_data_t lq_debug_bus0;
   perv_event_pkg::trace_data_t debug_bus_out;
   perv_event_pkg::coretrace_t  coretrace_ctrls_out;
   logic [THREADS-1:0]          msr_pr;
   logic [THREADS-1:0]          msr_gs;
   logic [EX6W-1:0]             ex6_events;
   logic [STQ4W-1:0]            stq4_events;
   logic [THREADS-1:0]          ex7_events;
   logic [EVW-1:0]              event_bus_in;
   logic [EVW-1:0]              event_bus_out;

   vec_t   vectors [NUM_VEC];
   integer seed;
   int     mismatches = 0;
   int     timeouts = 0;

   lq_perv_top #(.THREADS(THREADS)) u_dut (
      .nclk                      (nclk),
      .arst_n                    (arst_n),
      .psel                      (psel),
      .penable                   (penable),
      .pwrite                    (pwrite),
      .paddr                     (paddr),
      .pwdata                    (pwdata),
      .prdata                    (prdata),
      .pready                    (pready),
      .pslverr                   (pslverr),
      .debug_bus_in              (debug_bus_in),
      .coretrace_ctrls_in        (coretrace_ctrls_in),
      .lq_debug_bus0             (lq_debug_bus0),
      .debug_bus_out             (debug_bus_out),
      .coretrace_ctrls_out       (coretrace_ctrls_out),
      .xu_lq_spr_msr_pr          (msr_pr),
      .xu_lq_spr_msr_gs          (msr_gs),
      .ctl_perv_ex6_perf_events  (ex6_events),
      .ctl_perv_stq4_perf_events (stq4_events),
      .lsq_perv_ex7_events       (ex7_events),
      .event_bus_in              (event_bus_in),
      .event_bus_out             (event_bus_out)
   );

   initial begin
      nclk = 1'b0;
      forever #2 nclk = ~nclk;
   end

   // --------------------
   // reference model
   // --------------------
   function automatic perv_event_pkg::trace_data_t stage_model(input perv_cfg_pkg::dbg_sel_t sel,
      input perv_event_pkg::trace_data_t dbg, input perv_event_pkg::trace_data_t tin);
      perv_event_pkg::trace_data_t res;
      int rot;
      int src;
      res = tin;
      rot = int'(sel[1:0]);
      for (int i = 0; i < 4; i++) begin
         // byte i of a left rotate comes from byte i-rot
         src = (i - rot + 4) % 4;
         if (sel[2+i]) begin
            res[8*i +: 8] = dbg[8*src +: 8];
         end
      end
      return res;
   endfunction

   function automatic logic count_model(input perv_cfg_pkg::count_mode_t mode, input logic pr,
      input logic gs);
      if (pr) begin
         return mode[2];
      end else if (gs) begin
         return mode[1];
      end
      return mode[0];
   endfunction

   // ex6 at 6..23, stq4 at 24..29 and ex7 at 30 with the rest zero
   function automatic logic event_model(input int idx, input int t, input logic [EX6W-1:0] ex6,
      input logic [STQ4W-1:0] stq4, input logic [THREADS-1:0] ex7);
      logic val;
      val = 1'b0;
      if (idx >= 6 && idx < 24) begin
         val = ex6[idx-6] & ex6[18+t];
      end else if (idx >= 24 && idx < 30) begin
         val = stq4[idx-24] & stq4[6+t];
      end else if (idx == 30) begin
         val = ex7[t];
      end
      return val;
   endfunction

   function automatic logic [EVW-1:0] events_model(input vec_t v);
      logic [EVW-1:0] res;
      logic           en;
      logic           ev;
      int             idx;
      res = '0;
      for (int t = 0; t < THREADS; t++) begin
         en = count_model(v.mode, v.pr[t], v.gs[t]);
         for (int k = 0; k < LANES; k++) begin
            idx = int'(v.lesr[t*24 + 6*k +: 6]);
            ev = event_model(idx, t, v.ex6, v.stq4, v.ex7);
            res[t*LANES + k] = (en & ev) | v.ev_in[t*LANES + k];
         end
      end
      return res;
   endfunction

   // --------------------
   // compare tasks
   // --------------------
   task automatic check_trace(input perv_event_pkg::trace_data_t got,
      input perv_event_pkg::trace_data_t exp, input string msg);
      if (got !== exp) begin
         mismatches++;
         $display("MISMATCH at %0t ns: %s got %h expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic check_coretrace(input perv_event_pkg::coretrace_t got,
      input perv_event_pkg::coretrace_t exp, input string msg);
      if (got !== exp) begin
         mismatches++;
         $display("MISMATCH at %0t ns: %s got %h expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic check_events(input logic [EVW-1:0] got, input logic [EVW-1:0] exp,
      input string msg);
      if (got !== exp) begin
         mismatches++;
         $display("MISMATCH at %0t ns: %s got %b expected %b", $time, msg, got, exp);
      end
   endtask

   task automatic check_apb(input perv_cfg_pkg::apb_data_t got,
      input perv_cfg_pkg::apb_data_t exp, input string msg);
      if (got !== exp) begin
         mismatches++;
         $display("MISMATCH at %0t ns: %s got %h expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string msg);
      if (got !== exp) begin
         mismatches++;
         $display("MISMATCH at %0t ns: %s got %b expected %b", $time, msg, got, exp);
      end
   endtask

   task automatic finish_run;
      $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
      if (mismatches == 0 && timeouts == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   endtask

   // --------------------
   // apb access
   // --------------------
   // called and left one step after a rising edge
   task automatic apb_access(input logic write, input perv_cfg_pkg::apb_addr_t addr,
      input perv_cfg_pkg::apb_data_t wdata, output perv_cfg_pkg::apb_data_t rdata,
      output logic err);
      int cycles;
      cycles = 0;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge nclk);
      #1;
      penable = 1'b1;
      @(negedge nclk);
      // pready is high from the first access cycle
      check_flag(pready, 1'b1, "pready in access phase");
      while (!pready && cycles < TIMEOUT) begin
         @(negedge nclk);
         cycles++;
      end
      if (!pready) begin
         timeouts++;
         $display("ERROR: no pready within %0d cycles for address %h", TIMEOUT, addr);
         finish_run();
      end else begin
         rdata = prdata;
         err   = pslverr;
         @(posedge nclk);
         #1;
         psel    = 1'b0;
         penable = 1'b0;
         pwrite  = 1'b0;
      end
   endtask

   task automatic apb_write(input perv_cfg_pkg::apb_addr_t addr,
      input perv_cfg_pkg::apb_data_t data);
      perv_cfg_pkg::apb_data_t rdata;
      logic err;
      apb_access(1'b1, addr, data, rdata, err);
   endtask

   task automatic apb_read(input perv_cfg_pkg::apb_addr_t addr,
      input perv_cfg_pkg::apb_data_t exp, input logic exp_err, input string msg);
      perv_cfg_pkg::apb_data_t rdata;
      logic err;
      apb_access(1'b0, addr, '0, rdata, err);
      check_apb(rdata, exp, msg);
      check_flag(err, exp_err, {msg, " pslverr"});
   endtask

   // --------------------
   // test sequences
   // --------------------
   task automatic check_registers;
      perv_cfg_pkg::apb_data_t val;
      @(negedge nclk);
      check_trace(debug_bus_out, '0, "reset debug_bus_out");
      check_coretrace(coretrace_ctrls_out, '0, "reset coretrace_ctrls_out");
      check_events(event_bus_out, '0, "reset event_bus_out");
      check_apb(prdata, '0, "reset prdata");
      check_flag(pslverr, 1'b0, "reset pslverr");
      @(posedge nclk);
      #1;
      apb_read(perv_cfg_pkg::ADDR_CTRL, 32'h0, 1'b0, "reset ctrl");
      apb_read(perv_cfg_pkg::ADDR_DBG_SEL, 32'h0, 1'b0, "reset dbg_sel");
      apb_read(8'h08, 32'h0, 1'b0, "reset lesr0");
      apb_read(8'h0c, 32'h0, 1'b0, "reset lesr1");
      // first address past the thread registers
      apb_read(8'h10, 32'h0, 1'b1, "unmapped read");
      apb_write(perv_cfg_pkg::ADDR_CTRL, 32'hffff_ffff);
      apb_read(perv_cfg_pkg::ADDR_CTRL, 32'h0000_0073, 1'b0, "ctrl readback");
      apb_write(perv_cfg_pkg::ADDR_DBG_SEL, 32'hffff_ffff);
      apb_read(perv_cfg_pkg::ADDR_DBG_SEL, 32'h0000_3f3f, 1'b0, "dbg_sel readback");
      val = $random(seed);
      apb_write(8'h0c, val);
      apb_read(8'h0c, val & 32'h00ff_ffff, 1'b0, "lesr1 readback");
      apb_write(8'h10, 32'hffff_ffff);
      apb_read(8'h10, 32'h0, 1'b1, "unmapped read after write");
      apb_read(perv_cfg_pkg::ADDR_CTRL, 32'h0000_0073, 1'b0, "ctrl after unmapped write");
   endtask

   task automatic build_vectors;
      vec_t v;
      int   state;
      int   r;
      for (int i = 0; i < NUM_VEC; i++) begin
         v        = '0;
         v.mode   = 3'(i % 8);
         v.sel1   = 6'($random(seed));
         v.sel2   = 6'($random(seed));
         v.dbg_in = $random(seed);
         v.lq_dbg = $random(seed);
         v.ct_in  = 4'($random(seed));
         v.ex6    = EX6W'($random(seed));
         v.stq4   = STQ4W'($random(seed));
         v.ex7    = THREADS'($random(seed));
         v.ev_in  = EVW'($random(seed) & $random(seed));
         for (int t = 0; t < THREADS; t++) begin
            // 0 hypervisor, 1 guest supervisor, 2 user
            state = (i / 8 + t) % 3;
            r = $random(seed) & 32'h7fff_ffff;
            v.pr[t] = (state == 2);
            v.gs[t] = (state == 1) || (state == 2 && r[0]);
            for (int k = 0; k < LANES; k++) begin
               r = $random(seed) & 32'h7fff_ffff;
               v.lesr[t*24 + 6*k +: 6] = 6'((k == 3) ? r % 64 : r % 31);
            end
         end
         if (i % 4 == 0) begin
            v.lesr[5:0] = 6'd0;
         end
         v.exp_trace  = stage_model(v.sel2, v.lq_dbg, stage_model(v.sel1, v.lq_dbg, v.dbg_in));
         v.exp_events = events_model(v);
         vectors[i]   = v;
      end
   endtask

   task automatic run_vector(input vec_t v, input int n);
      string tag;
      tag = $sformatf("vector %0d", n);
      apb_write(perv_cfg_pkg::ADDR_CTRL, perv_cfg_pkg::apb_data_t'({v.mode, 4'b0011}));
      apb_write(perv_cfg_pkg::ADDR_DBG_SEL,
                perv_cfg_pkg::apb_data_t'({2'b00, v.sel2, 2'b00, v.sel1}));
      for (int t = 0; t < THREADS; t++) begin
         apb_write(perv_cfg_pkg::ADDR_LESR_BASE + 8'(4 * t),
                   perv_cfg_pkg::apb_data_t'(v.lesr[t*24 +: 24]));
      end
      // trace data and machine state go first while events stay quiet
      debug_bus_in       = v.dbg_in;
      lq_debug_bus0      = v.lq_dbg;
      coretrace_ctrls_in = v.ct_in;
      msr_pr             = v.pr;
      msr_gs             = v.gs;
      ex6_events         = '0;
      stq4_events        = '0;
      ex7_events         = '0;
      event_bus_in       = '0;
      repeat (2) @(posedge nclk);
      #1;
      ex6_events   = v.ex6;
      stq4_events  = v.stq4;
      ex7_events   = v.ex7;
      event_bus_in = v.ev_in;
      @(negedge nclk);
      check_trace(debug_bus_out, v.exp_trace, {tag, " debug_bus_out"});
      check_coretrace(coretrace_ctrls_out, v.ct_in, {tag, " coretrace_ctrls_out"});
      check_events(event_bus_out, '0, {tag, " event_bus_out before events"});
      @(posedge nclk);
      @(negedge nclk);
      check_events(event_bus_out, v.exp_events, {tag, " event_bus_out"});
      @(posedge nclk);
      #1;
   endtask

   task automatic check_hold(input vec_t last);
      apb_write(perv_cfg_pkg::ADDR_CTRL, 32'h0);
      for (int n = 0; n < 6; n++) begin
         debug_bus_in       = $random(seed);
         lq_debug_bus0      = $random(seed);
         coretrace_ctrls_in = 4'($random(seed));
         msr_pr             = THREADS'($random(seed));
         msr_gs             = THREADS'($random(seed));
         ex6_events         = EX6W'($random(seed));
         stq4_events        = STQ4W'($random(seed));
         ex7_events         = THREADS'($random(seed));
         event_bus_in       = EVW'($random(seed));
         @(posedge nclk);
         #1;
      end
      @(negedge nclk);
      check_trace(debug_bus_out, last.exp_trace, "held debug_bus_out");
      check_coretrace(coretrace_ctrls_out, last.ct_in, "held coretrace_ctrls_out");
      check_events(event_bus_out, last.exp_events, "held event_bus_out");
   endtask

   initial begin
      seed               = 32'h45e6_0916;
      arst_n             = 1'b0;
      psel               = 1'b0;
      penable            = 1'b0;
      pwrite             = 1'b0;
      paddr              = '0;
      pwdata             = '0;
      debug_bus_in       = '0;
      coretrace_ctrls_in = '0;
      lq_debug_bus0      = '0;
      msr_pr             = '0;
      msr_gs             = '0;
      ex6_events         = '0;
      stq4_events        = '0;
      ex7_events         = '0;
      event_bus_in       = '0;
      repeat (16) @(posedge nclk);
      #1;
      arst_n = 1'b1;
      check_registers();
      build_vectors();
      for (int i = 0; i < NUM_VEC; i++) begin
         run_vector(vectors[i], i);
      end
      check_hold(vectors[NUM_VEC-1]);
      finish_run();
   end

endmodule

`default_nettype wire

// File: src/lq_perv_top.sv
// Load/store pervasive debug and events
`timescale 1ns/1ps
`default_nettype none

module lq_perv_top #(
   parameter int THREADS = 2
) (
   input  wire logic                                          nclk,
   input  wire logic                                          arst_n,
   // apb slave
   input  wire logic                                          psel,
   input  wire logic                                          penable,
   input  wire logic                                          pwrite,
   input  wire perv_cfg_pkg::apb_addr_t                       paddr,
   input  wire perv_cfg_pkg::apb_data_t                       pwdata,
   output perv_cfg_pkg::apb_data_t                            prdata,
   output logic                                               pready,
   output logic                                               pslverr,
   // trace
   input  wire perv_event_pkg::trace_data_t                   debug_bus_in,
   input  wire perv_event_pkg::coretrace_t                    coretrace_ctrls_in,
   input  wire perv_event_pkg::trace_data_t                   lq_debug_bus0,
   output perv_event_pkg::trace_data_t                        debug_bus_out,
   output perv_event_pkg::coretrace_t                         coretrace_ctrls_out,
   // events
   input  wire logic [THREADS-1:0]                            xu_lq_spr_msr_pr,
   input  wire logic [THREADS-1:0]                            xu_lq_spr_msr_gs,
   input  wire logic [perv_event_pkg::EX6_EVENTS+THREADS-1:0]  ctl_perv_ex6_perf_events,
   input  wire logic [perv_event_pkg::STQ4_EVENTS+THREADS-1:0] ctl_perv_stq4_perf_events,
   input  wire logic [THREADS-1:0]                            lsq_perv_ex7_events,
   input  wire logic [THREADS*perv_event_pkg::EVENT_LANES-1:0] event_bus_in,
   output logic [THREADS*perv_event_pkg::EVENT_LANES-1:0]      event_bus_out
);

   localparam int LESR_W = $bits(perv_cfg_pkg::lesr_t);
   localparam int EV_W   = $bits(perv_event_pkg::unit_events_t);

   if (THREADS < 1 || THREADS > 4) begin : g_bad_threads
      $error("lq_perv_top: THREADS must be 1 to 4");
   end

   logic                        trace_en;
   logic                        event_en;
   perv_cfg_pkg::count_mode_t   count_mode;
   perv_cfg_pkg::dbg_sel_t      dbg_sel1;
   perv_cfg_pkg::dbg_sel_t      dbg_sel2;
   logic [THREADS*LESR_W-1:0]   lesr;
   perv_event_pkg::trace_data_t stage1_trace;
   perv_event_pkg::coretrace_t  stage1_coretrace;
   logic [THREADS*EV_W-1:0]     unit_events;

   // --------------------
   // configuration
   // --------------------
   perv_cfg_regs #(.THREADS(THREADS)) u_cfg_regs (
      .nclk       (nclk),
      .arst_n     (arst_n),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .trace_en   (trace_en),
      .event_en   (event_en),
      .count_mode (count_mode),
      .dbg_sel1   (dbg_sel1),
      .dbg_sel2   (dbg_sel2),
      .lesr       (lesr)
   );

   // --------------------
   // trace chain
   // --------------------
   debug_trace_stage u_dbg_stage1 (
      .nclk          (nclk),
      .arst_n        (arst_n),
      .trace_en      (trace_en),
      .sel           (dbg_sel1),
      .debug_data    (lq_debug_bus0),
      .trace_in      (debug_bus_in),
      .coretrace_in  (coretrace_ctrls_in),
      .trace_out     (stage1_trace),
      .coretrace_out (stage1_coretrace)
   );

   debug_trace_stage u_dbg_stage2 (
      .nclk          (nclk),
      .arst_n        (arst_n),
      .trace_en      (trace_en),
      .sel           (dbg_sel2),
      .debug_data    (lq_debug_bus0),
      .trace_in      (stage1_trace),
      .coretrace_in  (stage1_coretrace),
      .trace_out     (debug_bus_out),
      .coretrace_out (coretrace_ctrls_out)
   );

   // --------------------
   // event path
   // --------------------
   perf_thread_events #(.THREADS(THREADS)) u_thread_events (
      .nclk        (nclk),
      .arst_n      (arst_n),
      .event_en    (event_en),
      .count_mode  (count_mode),
      .msr_pr      (xu_lq_spr_msr_pr),
      .msr_gs      (xu_lq_spr_msr_gs),
      .ex6_events  (ctl_perv_ex6_perf_events),
      .stq4_events (ctl_perv_stq4_perf_events),
      .ex7_events  (lsq_perv_ex7_events),
      .unit_events (unit_events)
   );

   perf_event_select #(.THREADS(THREADS)) u_event_select (
      .nclk          (nclk),
      .arst_n        (arst_n),
      .event_en      (event_en),
      .lesr          (lesr),
      .unit_events   (unit_events),
      .event_bus_in  (event_bus_in),
      .event_bus_out (event_bus_out)
   );

endmodule

`default_nettype wire

// File: src/perf_event_select.sv
// Event bus lane select
`timescale 1ns/1ps
`default_nettype none

module perf_event_select #(
   parameter int THREADS = 2
) (
   input  wire logic                                                nclk,
   input  wire logic                                                arst_n,
   input  wire logic                                                event_en,
   input  wire logic [THREADS*$bits(perv_cfg_pkg::lesr_t)-1:0]       lesr,
   input  wire logic [THREADS*$bits(perv_event_pkg::unit_events_t)-1:0] unit_events,
   input  wire logic [THREADS*perv_event_pkg::EVENT_LANES-1:0]       event_bus_in,
   output logic [THREADS*perv_event_pkg::EVENT_LANES-1:0]            event_bus_out
);

   localparam int LANES  = perv_event_pkg::EVENT_LANES;
   localparam int LESR_W = $bits(perv_cfg_pkg::lesr_t);
   localparam int EV_W   = $bits(perv_event_pkg::unit_events_t);
   localparam int IDX_W  = $bits(perv_event_pkg::event_idx_t);

   logic [THREADS*LANES-1:0] event_bus_d;

   // --------------------
   // lane mux
   // --------------------
   always_comb begin
      perv_event_pkg::event_idx_t   idx;
      perv_event_pkg::unit_events_t vec;
      idx = '0;
      vec = '0;
      for (int t = 0; t < THREADS; t++) begin
         vec = unit_events[t*EV_W +: EV_W];
         for (int k = 0; k < LANES; k++) begin
            idx = lesr[t*LESR_W + k*IDX_W +: IDX_W];
            // incoming lane merges in, so index 0 is a pass-through
            event_bus_d[t*LANES + k] = vec[idx] | event_bus_in[t*LANES + k];
         end
      end
   end

   // output register holds while events are disabled
   always_ff @(posedge nclk or negedge arst_n) begin
      if (!arst_n) begin
         event_bus_out <= '0;
      end else if (event_en) begin
         event_bus_out <= event_bus_d;
      end
   end

endmodule

`default_nettype wire

// File: src/perf_thread_events.sv
// Per-thread performance event vector
`timescale 1ns/1ps
`default_nettype none

module perf_thread_events #(
   parameter int THREADS = 2
) (
   input  wire logic                                          nclk,
   input  wire logic                                          arst_n,
   input  wire logic                                          event_en,
   input  wire perv_cfg_pkg::count_mode_t                     count_mode,
   input  wire logic [THREADS-1:0]                            msr_pr,
   input  wire logic [THREADS-1:0]                            msr_gs,
   input  wire logic [perv_event_pkg::EX6_EVENTS+THREADS-1:0]  ex6_events,
   input  wire logic [perv_event_pkg::STQ4_EVENTS+THREADS-1:0] stq4_events,
   input  wire logic [THREADS-1:0]                            ex7_events,
   output logic [THREADS*$bits(perv_event_pkg::unit_events_t)-1:0] unit_events
);

   localparam int EV_W   = $bits(perv_event_pkg::unit_events_t);
   localparam int EX6_N  = perv_event_pkg::EX6_EVENTS;
   localparam int STQ4_N = perv_event_pkg::STQ4_EVENTS;

   logic [THREADS-1:0] msr_pr_q;
   logic [THREADS-1:0] msr_gs_q;
   logic [THREADS-1:0] count_en_d;
   logic [THREADS-1:0] count_en_q;

   // --------------------
   // machine state sampling
   // --------------------
   always_ff @(posedge nclk or negedge arst_n) begin
      if (!arst_n) begin
         msr_pr_q <= '0;
         msr_gs_q <= '0;
      end else begin
         msr_pr_q <= msr_pr;
         msr_gs_q <= msr_gs;
      end
   end

   // user, guest supervisor, hypervisor
   assign count_en_d =
      ( msr_pr_q &            {THREADS{count_mode[perv_cfg_pkg::CM_USER_BIT]}})  |
      (~msr_pr_q &  msr_gs_q & {THREADS{count_mode[perv_cfg_pkg::CM_GUEST_BIT]}}) |
      (~msr_pr_q & ~msr_gs_q & {THREADS{count_mode[perv_cfg_pkg::CM_HYP_BIT]}});

   always_ff @(posedge nclk or negedge arst_n) begin
      if (!arst_n) begin
         count_en_q <= '0;
      end else if (event_en) begin
         count_en_q <= count_en_d;
      end
   end

   // --------------------
   // event vector per thread
   // --------------------
   for (genvar t = 0; t < THREADS; t++) begin : g_thread
      perv_event_pkg::unit_events_t vec;

      always_comb begin
         vec = '0;
         // shared group bits only count for the thread that owns them
         vec[perv_event_pkg::EVT_EX6_BASE +: EX6_N] =
            ex6_events[EX6_N-1:0] & {EX6_N{ex6_events[EX6_N+t]}};
         vec[perv_event_pkg::EVT_STQ4_BASE +: STQ4_N] =
            stq4_events[STQ4_N-1:0] & {STQ4_N{stq4_events[STQ4_N+t]}};
         vec[perv_event_pkg::EVT_EX7] = ex7_events[t];
      end

      assign unit_events[t*EV_W +: EV_W] = vec & {EV_W{count_en_q[t]}};
   end

endmodule

`default_nettype wire

// File: src/debug_trace_stage.sv
// Debug trace mux stage
`timescale 1ns/1ps
`default_nettype none

module debug_trace_stage (
   input  wire logic                        nclk,
   input  wire logic                        arst_n,
   input  wire logic                        trace_en,
   input  wire perv_cfg_pkg::dbg_sel_t      sel,
   input  wire perv_event_pkg::trace_data_t debug_data,
   input  wire perv_event_pkg::trace_data_t trace_in,
   input  wire perv_event_pkg::coretrace_t  coretrace_in,
   output perv_event_pkg::trace_data_t      trace_out,
   output perv_event_pkg::coretrace_t       coretrace_out
);

   localparam int BYTES = perv_event_pkg::TRACE_BYTES;
   localparam int DW    = $bits(perv_event_pkg::trace_data_t);

   logic [perv_cfg_pkg::SEL_ROT_W-1:0] rot;
   logic [BYTES-1:0]                   lane_en;
   perv_event_pkg::trace_data_t        rotated;
   perv_event_pkg::trace_data_t        merged;

   assign rot     = sel[perv_cfg_pkg::SEL_ROT_LSB +: perv_cfg_pkg::SEL_ROT_W];
   assign lane_en = sel[perv_cfg_pkg::SEL_LANE_LSB +: BYTES];

   // --------------------
   // rotate and merge
   // --------------------
   // left rotate by whole bytes, rot of 0 leaves data in place
   assign rotated = (debug_data << (8 * rot)) | (debug_data >> (DW - 8 * rot));

   always_comb begin
      for (int i = 0; i < BYTES; i++) begin
         merged[8*i +: 8] = lane_en[i] ? rotated[8*i +: 8] : trace_in[8*i +: 8];
      end
   end

   // --------------------
   // stage register
   // --------------------
   always_ff @(posedge nclk or negedge arst_n) begin
      if (!arst_n) begin
         trace_out     <= '0;
         coretrace_out <= '0;
      end else if (trace_en) begin
         trace_out     <= merged;
         coretrace_out <= coretrace_in;
      end
   end

   // select comes from the config block and must be settled while tracing
   a_sel_known: assert property (@(posedge nclk) disable iff (!arst_n)
      trace_en |-> !$isunknown(sel));

endmodule

`default_nettype wire

// File: src/perv_cfg_regs.sv
// APB configuration registers
`timescale 1ns/1ps
`default_nettype none

module perv_cfg_regs #(
   parameter int THREADS = 2
) (
   input  wire logic                                   nclk,
   input  wire logic                                   arst_n,
   input  wire logic                                   psel,
   input  wire logic                                   penable,
   input  wire logic                                   pwrite,
   input  wire perv_cfg_pkg::apb_addr_t                paddr,
   input  wire perv_cfg_pkg::apb_data_t                pwdata,
   output perv_cfg_pkg::apb_data_t                     prdata,
   output logic                                        pready,
   output logic                                        pslverr,
   output logic                                        trace_en,
   output logic                                        event_en,
   output perv_cfg_pkg::count_mode_t                   count_mode,
   output perv_cfg_pkg::dbg_sel_t                      dbg_sel1,
   output perv_cfg_pkg::dbg_sel_t                      dbg_sel2,
   output logic [THREADS*$bits(perv_cfg_pkg::lesr_t)-1:0] lesr
);

   localparam int LESR_W = $bits(perv_cfg_pkg::lesr_t);
   localparam int CM_W   = $bits(perv_cfg_pkg::count_mode_t);
   localparam int SEL_W  = $bits(perv_cfg_pkg::dbg_sel_t);

   logic                    access;
   logic                    ctrl_hit;
   logic                    dsel_hit;
   logic [THREADS-1:0]      lesr_hit;
   logic                    addr_hit;
   perv_cfg_pkg::apb_data_t rdata;

   // --------------------
   // address decode
   // --------------------
   always_comb begin
      ctrl_hit = (paddr == perv_cfg_pkg::ADDR_CTRL);
      dsel_hit = (paddr == perv_cfg_pkg::ADDR_DBG_SEL);
      for (int t = 0; t < THREADS; t++) begin
         lesr_hit[t] = (paddr == perv_cfg_pkg::ADDR_LESR_BASE + 8'(4 * t));
      end
   end

   assign access   = psel & penable;
   assign addr_hit = ctrl_hit | dsel_hit | (|lesr_hit);

   // no wait states
   assign pready  = 1'b1;
   assign pslverr = access & ~addr_hit;

   // --------------------
   // register writes
   // --------------------
   always_ff @(posedge nclk or negedge arst_n) begin
      if (!arst_n) begin
         trace_en   <= 1'b0;
         event_en   <= 1'b0;
         count_mode <= '0;
         dbg_sel1   <= '0;
         dbg_sel2   <= '0;
         lesr       <= '0;
      end else if (access && pwrite) begin
         if (ctrl_hit) begin
            trace_en   <= pwdata[perv_cfg_pkg::CTRL_TRACE_EN_BIT];
            event_en   <= pwdata[perv_cfg_pkg::CTRL_EVENT_EN_BIT];
            count_mode <= pwdata[perv_cfg_pkg::CTRL_COUNT_MODE_LSB +: CM_W];
         end
         if (dsel_hit) begin
            dbg_sel1 <= pwdata[perv_cfg_pkg::DBG_SEL1_LSB +: SEL_W];
            dbg_sel2 <= pwdata[perv_cfg_pkg::DBG_SEL2_LSB +: SEL_W];
         end
         for (int t = 0; t < THREADS; t++) begin
            if (lesr_hit[t]) begin
               lesr[t*LESR_W +: LESR_W] <= pwdata[LESR_W-1:0];
            end
         end
      end
   end

   // readback, zero for unmapped addresses
   always_comb begin
      rdata = '0;
      if (ctrl_hit) begin
         rdata[perv_cfg_pkg::CTRL_TRACE_EN_BIT]            = trace_en;
         rdata[perv_cfg_pkg::CTRL_EVENT_EN_BIT]            = event_en;
         rdata[perv_cfg_pkg::CTRL_COUNT_MODE_LSB +: CM_W]  = count_mode;
      end
      if (dsel_hit) begin
         rdata[perv_cfg_pkg::DBG_SEL1_LSB +: SEL_W] = dbg_sel1;
         rdata[perv_cfg_pkg::DBG_SEL2_LSB +: SEL_W] = dbg_sel2;
      end
      for (int t = 0; t < THREADS; t++) begin
         if (lesr_hit[t]) begin
            rdata[LESR_W-1:0] = lesr[t*LESR_W +: LESR_W];
         end
      end
   end

   assign prdata = access ? rdata : '0;

   // an error response only ever ends a proper setup/access sequence
   a_slverr_in_access: assert property (@(posedge nclk) disable iff (!arst_n)
      pslverr |-> (psel && penable && $past(psel && !penable)));

endmodule

`default_nettype wire

// File: src/perv_event_pkg.sv
// Trace and performance event definitions
`default_nettype none

package perv_event_pkg;

   // --------------------
   // trace bus
   // --------------------
   typedef logic [31:0] trace_data_t;
   typedef logic [3:0]  coretrace_t;

   localparam int TRACE_BYTES = 4;

   // --------------------
   // event bus
   // --------------------
   // bit 0 of the unit vector never carries an event
   typedef logic [63:0] unit_events_t;
   typedef logic [5:0]  event_idx_t;

   localparam int EVENT_LANES = 4;

   // source group sizes
   localparam int EX6_EVENTS  = 18;
   localparam int STQ4_EVENTS = 6;

   // event numbering
   //   6..23   ex6 group
   //   24..29  stq4 group
   //   30      per-thread ex7 event
   // everything else reads as zero
   localparam int EVT_EX6_BASE  = 6;
   localparam int EVT_STQ4_BASE = 24;
   localparam int EVT_EX7       = 30;

endpackage

`default_nettype wire

// File: src/perv_cfg_pkg.sv
// Pervasive configuration definitions
`default_nettype none

package perv_cfg_pkg;

   // --------------------
   // apb bus
   // --------------------
   typedef logic [7:0]  apb_addr_t;
   typedef logic [31:0] apb_data_t;

   // register map
   localparam apb_addr_t ADDR_CTRL      = 8'h00;
   localparam apb_addr_t ADDR_DBG_SEL   = 8'h04;
   // one event select register per thread, 4 bytes apart
   localparam apb_addr_t ADDR_LESR_BASE = 8'h08;

   // --------------------
   // field layouts
   // --------------------
   localparam int CTRL_TRACE_EN_BIT   = 0;
   localparam int CTRL_EVENT_EN_BIT   = 1;
   localparam int CTRL_COUNT_MODE_LSB = 4;

   localparam int DBG_SEL1_LSB = 0;
   localparam int DBG_SEL2_LSB = 8;

   // stage select: low bits rotate, upper bits are byte-lane enables
   typedef logic [5:0] dbg_sel_t;
   localparam int SEL_ROT_LSB  = 0;
   localparam int SEL_ROT_W    = 2;
   localparam int SEL_LANE_LSB = 2;

   // count mode bits by machine state
   typedef logic [2:0] count_mode_t;
   localparam int CM_USER_BIT  = 2;
   localparam int CM_GUEST_BIT = 1;
   localparam int CM_HYP_BIT   = 0;

   // four 6-bit event indices, lane k at bits 6k+5:6k
   typedef logic [23:0] lesr_t;

endpackage

`default_nettype wire
